//--- dac_tpl_pkg.sv
// link sizes, register addresses, source-select codes and register word types
package dac_tpl_pkg;

  // ****************************************
  // link framing
  // ****************************************

  localparam int num_lanes = 2;
  localparam int num_channels = 2;
  localparam int octets_per_beat = 4;
  localparam int bits_per_sample = 16;
  localparam int samples_per_beat = 2;

  // one lane per converter, high byte first
  localparam int link_data_width = num_lanes * octets_per_beat * 8;
  localparam int dma_data_width = num_channels * samples_per_beat * bits_per_sample;

  // ****************************************
  // register map
  // ****************************************

  localparam logic [31:0] core_id = 32'h6a54_0d01;

  // np in [23:16], channels in [15:8], lanes in [7:0]
  localparam logic [31:0] link_params = {
    8'd0,
    8'(bits_per_sample),
    8'(num_channels),
    8'(num_lanes)
  };

  localparam logic [7:0] reg_addr_id = 8'h00;
  localparam logic [7:0] reg_addr_link = 8'h01;
  localparam logic [7:0] reg_addr_status = 8'h02;
  // base addresses, channel index added on top
  localparam logic [7:0] reg_addr_chan_ctrl = 8'h10;
  localparam logic [7:0] reg_addr_pattern = 8'h20;

  // sample source select
  localparam logic [1:0] src_dma = 2'd0;
  localparam logic [1:0] src_pattern = 2'd1;
  localparam logic [1:0] src_ramp = 2'd2;
  localparam logic [1:0] src_zero = 2'd3;

  // channel control view
  typedef struct packed {
    logic [26:0] rsvd_hi;
    logic        enable;
    logic [1:0]  rsvd_lo;
    logic [1:0]  data_sel;
  } chan_ctrl_t;

  // pattern pair view, pat0 goes out first
  typedef struct packed {
    logic [15:0] pat1;
    logic [15:0] pat0;
  } pattern_t;

  // write word, decoded by address
  typedef union packed {
    chan_ctrl_t ctrl;
    pattern_t   pat;
  } reg_word_u;

endpackage

//--- dac_tpl_regmap.sv
// register decode with channel control, pattern, status and read-back
`timescale 1ns/100ps

module dac_tpl_regmap (
  input  logic                                            link_clk,
  input  logic                                            rst_n,
  input  logic                                            reg_wr,
  input  logic                                            reg_rd,
  input  logic [7:0]                                      reg_addr,
  input  dac_tpl_pkg::reg_word_u                          reg_wdata,
  output logic [31:0]                                     reg_rdata,
  output logic                                            reg_rvalid,
  input  logic                                            dac_dunf,
  output logic [dac_tpl_pkg::num_channels-1:0]            chan_enable,
  output logic [dac_tpl_pkg::num_channels-1:0][1:0]       chan_sel,
  output logic [dac_tpl_pkg::num_channels-1:0][15:0]      pat0,
  output logic [dac_tpl_pkg::num_channels-1:0][15:0]      pat1,
  output logic [dac_tpl_pkg::num_channels-1:0]            ramp_restart
);

  import dac_tpl_pkg::*;

  logic [num_channels-1:0] ctrl_hit;
  logic [num_channels-1:0] pat_hit;
  logic                    status_hit;
  logic                    dunf_flag;
  logic [31:0]             rdata_next;

  // ****************************************
  // address decode
  // ****************************************

  always_comb begin
    for (int c = 0; c < num_channels; c++) begin
      ctrl_hit[c] = (reg_addr == reg_addr_chan_ctrl + 8'(c));
      pat_hit[c] = (reg_addr == reg_addr_pattern + 8'(c));
    end
  end

  assign status_hit = (reg_addr == reg_addr_status);

  // ****************************************
  // write side
  // ****************************************

  // control view of the write word
  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      chan_enable <= '0;
      chan_sel <= {num_channels{src_dma}};
      ramp_restart <= '0;
    end else begin
      for (int c = 0; c < num_channels; c++) begin
        if (reg_wr && ctrl_hit[c]) begin
          chan_enable[c] <= reg_wdata.ctrl.enable;
          chan_sel[c] <= reg_wdata.ctrl.data_sel;
        end
      end
      // any control write restarts that channel's ramp
      ramp_restart <= {num_channels{reg_wr}} & ctrl_hit;
    end
  end

  // pattern view of the write word
  always_ff @(posedge link_clk) begin
    for (int c = 0; c < num_channels; c++) begin
      if (reg_wr && pat_hit[c]) begin
        pat0[c] <= reg_wdata.pat.pat0;
        pat1[c] <= reg_wdata.pat.pat1;
      end
    end
  end

  // sticky underflow, a new underflow beats the clear
  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      dunf_flag <= 1'b0;
    end else if (dac_dunf) begin
      dunf_flag <= 1'b1;
    end else if (reg_wr && status_hit && reg_wdata[0]) begin
      dunf_flag <= 1'b0;
    end
  end

  // ****************************************
  // read side
  // ****************************************

  always_comb begin
    chan_ctrl_t ctrl_rd;
    rdata_next = '0;
    case (reg_addr)
      reg_addr_id:     rdata_next = core_id;
      reg_addr_link:   rdata_next = link_params;
      reg_addr_status: rdata_next = {31'd0, dunf_flag};
      default:         rdata_next = '0;
    endcase
    for (int c = 0; c < num_channels; c++) begin
      ctrl_rd = '0;
      ctrl_rd.enable = chan_enable[c];
      ctrl_rd.data_sel = chan_sel[c];
      if (ctrl_hit[c]) begin
        rdata_next = ctrl_rd;
      end
      if (pat_hit[c]) begin
        rdata_next = {pat1[c], pat0[c]};
      end
    end
  end

  // read data follows the strobe by one cycle
  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd;
    end
  end

  always_ff @(posedge link_clk) begin
    if (reg_rd) begin
      reg_rdata <= rdata_next;
    end
  end

  a_rvalid_follows_rd: assert property (
    @(posedge link_clk) disable iff (!rst_n)
    reg_rvalid == $past(reg_rd)
  );

endmodule

//--- dac_tpl_source.sv
// per-channel sample source selection, ramp counters and dma valid strobes
`timescale 1ns/100ps

module dac_tpl_source (
  input  logic                                         link_clk,
  input  logic                                         rst_n,
  input  logic                                         link_ready,
  input  logic [dac_tpl_pkg::num_channels-1:0]         chan_enable,
  input  logic [dac_tpl_pkg::num_channels-1:0][1:0]    chan_sel,
  input  logic [dac_tpl_pkg::num_channels-1:0][15:0]   pat0,
  input  logic [dac_tpl_pkg::num_channels-1:0][15:0]   pat1,
  input  logic [dac_tpl_pkg::num_channels-1:0]         ramp_restart,
  input  logic [dac_tpl_pkg::dma_data_width-1:0]       dac_ddata,
  output logic [dac_tpl_pkg::num_channels-1:0]         dac_valid,
  output logic [dac_tpl_pkg::num_channels-1:0]
               [dac_tpl_pkg::samples_per_beat-1:0][15:0] chan_samples
);

  import dac_tpl_pkg::*;

  logic [num_channels-1:0][15:0] ramp;
  logic [num_channels-1:0][15:0] ramp_base;
  logic [num_channels-1:0]       ramp_active;
  logic [num_channels-1:0][samples_per_beat-1:0][15:0] samples_next;

  // ****************************************
  // dma strobes and ramp state
  // ****************************************

  always_comb begin
    for (int c = 0; c < num_channels; c++) begin
      dac_valid[c] = link_ready && chan_enable[c] && (chan_sel[c] == src_dma);
      ramp_active[c] = chan_enable[c] && (chan_sel[c] == src_ramp);
      // restart takes effect on the same beat
      ramp_base[c] = ramp_restart[c] ? 16'd0 : ramp[c];
    end
  end

  // ****************************************
  // sample select
  // ****************************************

  always_comb begin
    for (int c = 0; c < num_channels; c++) begin
      samples_next[c] = '0;
      if (chan_enable[c]) begin
        case (chan_sel[c])
          src_dma: begin
            for (int s = 0; s < samples_per_beat; s++) begin
              samples_next[c][s] =
                dac_ddata[(c * samples_per_beat + s) * bits_per_sample +: bits_per_sample];
            end
          end
          src_pattern: begin
            samples_next[c][0] = pat0[c];
            samples_next[c][1] = pat1[c];
          end
          src_ramp: begin
            for (int s = 0; s < samples_per_beat; s++) begin
              samples_next[c][s] = ramp_base[c] + 16'(s);
            end
          end
          default: begin
            samples_next[c] = '0;
          end
        endcase
      end
    end
  end

  // ****************************************
  // beat registers
  // ****************************************

  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      chan_samples <= '0;
      ramp <= '0;
    end else begin
      if (link_ready) begin
        chan_samples <= samples_next;
      end
      for (int c = 0; c < num_channels; c++) begin
        if (link_ready && ramp_active[c]) begin
          ramp[c] <= ramp_base[c] + 16'(samples_per_beat);
        end else begin
          ramp[c] <= ramp_base[c];
        end
      end
    end
  end

  // no dma word may be taken while the link stalls
  a_no_valid_when_stalled: assert property (
    @(posedge link_clk) disable iff (!rst_n)
    !link_ready |-> (dac_valid == '0)
  );

endmodule

//--- dac_tpl_framer.sv
// lane octet framer driving link_data and link_valid
`timescale 1ns/100ps

module dac_tpl_framer (
  input  logic                                         link_clk,
  input  logic                                         rst_n,
  input  logic                                         link_ready,
  input  logic [dac_tpl_pkg::num_channels-1:0]
               [dac_tpl_pkg::samples_per_beat-1:0][15:0] chan_samples,
  output logic                                         link_valid,
  output logic [dac_tpl_pkg::link_data_width-1:0]      link_data
);

  import dac_tpl_pkg::*;

  localparam int lane_width = octets_per_beat * 8;

  logic [link_data_width-1:0] frame_next;

  // ****************************************
  // octet mapping
  // ****************************************

  // channel c rides on lane c
  // sample s fills octets 2s (high byte) and 2s+1 (low byte)
  always_comb begin
    frame_next = '0;
    for (int l = 0; l < num_lanes; l++) begin
      for (int s = 0; s < samples_per_beat; s++) begin
        frame_next[l * lane_width + (2 * s) * 8 +: 8] = chan_samples[l][s][15:8];
        frame_next[l * lane_width + (2 * s + 1) * 8 +: 8] = chan_samples[l][s][7:0];
      end
    end
  end

  // ****************************************
  // output register
  // ****************************************

  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      link_data <= '0;
    end else if (link_ready) begin
      link_data <= frame_next;
    end
  end

  // valid is a plain level once out of reset
  always_ff @(posedge link_clk) begin
    if (!rst_n) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= 1'b1;
    end
  end

  a_hold_on_stall: assert property (
    @(posedge link_clk) disable iff (!rst_n)
    !link_ready |=> $stable(link_data)
  );

endmodule

//--- dac_tpl_top.sv
// top level connecting regmap, sample source and lane framer
`timescale 1ns/100ps

module dac_tpl_top (
  input  logic                                    link_clk,
  input  logic                                    rst_n,

  // register bus
  input  logic                                    reg_wr,
  input  logic                                    reg_rd,
  input  logic [7:0]                              reg_addr,
  input  dac_tpl_pkg::reg_word_u                  reg_wdata,
  output logic [31:0]                             reg_rdata,
  output logic                                    reg_rvalid,

  // link side
  output logic                                    link_valid,
  input  logic                                    link_ready,
  output logic [dac_tpl_pkg::link_data_width-1:0] link_data,

  // dma side
  output logic [dac_tpl_pkg::num_channels-1:0]    enable,
  output logic [dac_tpl_pkg::num_channels-1:0]    dac_valid,
  input  logic [dac_tpl_pkg::dma_data_width-1:0]  dac_ddata,
  input  logic                                    dac_dunf
);

  import dac_tpl_pkg::*;

  logic [num_channels-1:0]                        chan_enable;
  logic [num_channels-1:0][1:0]                   chan_sel;
  logic [num_channels-1:0][15:0]                  pat0;
  logic [num_channels-1:0][15:0]                  pat1;
  logic [num_channels-1:0]                        ramp_restart;
  logic [num_channels-1:0][samples_per_beat-1:0][15:0] chan_samples;

  assign enable = chan_enable;

  dac_tpl_regmap i_regmap (
    .link_clk     (link_clk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .reg_rvalid   (reg_rvalid),
    .dac_dunf     (dac_dunf),
    .chan_enable  (chan_enable),
    .chan_sel     (chan_sel),
    .pat0         (pat0),
    .pat1         (pat1),
    .ramp_restart (ramp_restart)
  );

  dac_tpl_source i_source (
    .link_clk     (link_clk),
    .rst_n        (rst_n),
    .link_ready   (link_ready),
    .chan_enable  (chan_enable),
    .chan_sel     (chan_sel),
    .pat0         (pat0),
    .pat1         (pat1),
    .ramp_restart (ramp_restart),
    .dac_ddata    (dac_ddata),
    .dac_valid    (dac_valid),
    .chan_samples (chan_samples)
  );

  dac_tpl_framer i_framer (
    .link_clk     (link_clk),
    .rst_n        (rst_n),
    .link_ready   (link_ready),
    .chan_samples (chan_samples),
    .link_valid   (link_valid),
    .link_data    (link_data)
  );

endmodule

//--- dac_tpl_tb.sv
// testbench with clock, reset, register tasks, lcg, reference function and link checker
`timescale 1ns/100ps

module dac_tpl_tb;

  import dac_tpl_pkg::*;

  logic                          link_clk;
  logic                          rst_n;
  logic                          reg_wr;
  logic                          reg_rd;
  logic [7:0]                    reg_addr;
  reg_word_u                     reg_wdata;
  logic [31:0]                   reg_rdata;
  logic                          reg_rvalid;
  logic                          link_valid;
  logic                          link_ready;
  logic [link_data_width-1:0]    link_data;
  logic [num_channels-1:0]       enable;
  logic [num_channels-1:0]       dac_valid;
  logic [dma_data_width-1:0]     dac_ddata;
  logic                          dac_dunf;

  int                            errors;
  int                            beats_checked;
  logic [31:0]                   lcg_state;
  logic                          check_dma;
  logic                          prev_accept;
  logic [link_data_width-1:0]    prev_data;
  logic [link_data_width-1:0]    exp_q[$];

  dac_tpl_top dut0 (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_data  (link_data),
    .enable     (enable),
    .dac_valid  (dac_valid),
    .dac_ddata  (dac_ddata),
    .dac_dunf   (dac_dunf)
  );

  always #10 link_clk = ~link_clk;

  // ****************************************
  // reference model and helpers
  // ****************************************

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // lane c carries channel c, high byte of each sample first
  function automatic logic [link_data_width-1:0] expected_beat(
    input logic [1:0][1:0][15:0] smp
  );
    logic [link_data_width-1:0] w;
    w = '0;
    for (int l = 0; l < 2; l++) begin
      for (int s = 0; s < 2; s++) begin
        w[l * 32 + 16 * s +: 8] = smp[l][s][15:8];
        w[l * 32 + 16 * s + 8 +: 8] = smp[l][s][7:0];
      end
    end
    return w;
  endfunction

  function automatic logic [15:0] lane_sample(input logic [link_data_width-1:0] w,
                                              input int l, input int s);
    return {w[l * 32 + 16 * s +: 8], w[l * 32 + 16 * s + 8 +: 8]};
  endfunction

  task automatic tick();
    @(posedge link_clk);
    #2;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    reg_wr = 1'b1;
    reg_addr = addr;
    reg_wdata = data;
    tick();
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    reg_rd = 1'b1;
    reg_addr = addr;
    tick();
    reg_rd = 1'b0;
    n = 0;
    while (!reg_rvalid && n < 10) begin
      tick();
      n++;
    end
    assert (reg_rvalid) else begin
      $display("read of register %h never returned valid data", addr);
      errors++;
    end
    // read data is due on the cycle right after the strobe
    assert (n == 0) else begin
      $display("read of register %h returned valid data %0d cycles late", addr, n);
      errors++;
    end
    data = reg_rdata;
    tick();
    assert (!reg_rvalid) else begin
      $display("error reg_rvalid expected %h actual %h", 1'b0, reg_rvalid);
      errors++;
    end
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    reg_read(addr, got);
    assert (got == exp) else begin
      $display("error reg_rdata addr %h expected %h actual %h", addr, exp, got);
      errors++;
    end
  endtask

  // link held ready, several flush beats, then a fixed expected word
  task automatic check_static(input logic [link_data_width-1:0] exp, input int n);
    link_ready = 1'b1;
    repeat (4) tick();
    repeat (n) begin
      assert (link_data == exp) else begin
        $display("error link_data expected %h actual %h", exp, link_data);
        errors++;
      end
      tick();
    end
  endtask

  // ****************************************
  // dma beat checker
  // ****************************************

  always @(posedge link_clk) begin
    if (check_dma && rst_n) begin
      if (!link_ready) begin
        assert (dac_valid == '0) else begin
          $display("error dac_valid expected %h actual %h", 2'h0, dac_valid);
          errors++;
        end
      end else begin
        assert (dac_valid == 2'b11) else begin
          $display("error dac_valid expected %h actual %h", 2'h3, dac_valid);
          errors++;
        end
      end
      if (!prev_accept) begin
        assert (link_data == prev_data) else begin
          $display("error link_data expected %h actual %h", prev_data, link_data);
          errors++;
        end
      end
      if (link_ready) begin
        if (exp_q.size() >= 2) begin
          prev_data = exp_q.pop_front();
          assert (link_data == prev_data) else begin
            $display("error link_data expected %h actual %h", prev_data, link_data);
            errors++;
          end
          beats_checked++;
        end
        // both channels on dma, every accepted beat takes a word
        exp_q.push_back(expected_beat(dac_ddata));
      end
      prev_accept = link_ready;
      prev_data = link_data;
    end
  end

  task automatic run_dma(input int n_beats, input logic random_ready);
    int cycles;
    reg_write(reg_addr_chan_ctrl, 32'h10);
    reg_write(reg_addr_chan_ctrl + 8'd1, 32'h10);
    link_ready = 1'b1;
    tick();
    exp_q.delete();
    beats_checked = 0;
    prev_accept = 1'b1;
    check_dma = 1'b1;
    cycles = 0;
    while (beats_checked < n_beats && cycles < n_beats * 10 + 50) begin
      if (dac_valid != '0 || cycles == 0) begin
        lcg_state = lcg_next(lcg_state);
        dac_ddata[31:0] = lcg_state;
        lcg_state = lcg_next(lcg_state);
        dac_ddata[63:32] = lcg_state;
      end
      lcg_state = lcg_next(lcg_state);
      link_ready = random_ready ? (lcg_state[15:8] < 8'd170) : 1'b1;
      tick();
      cycles++;
    end
    assert (beats_checked >= n_beats) else begin
      $display("timed out waiting for dma beats on link_data");
      errors++;
    end
    check_dma = 1'b0;
    link_ready = 1'b1;
  endtask

  // ****************************************
  // main sequence
  // ****************************************

  initial begin
    logic [31:0] rd;
    logic [15:0] prev_s0;
    logic [link_data_width-1:0] last;
    int n;
    int beats;
    link_clk = 1'b0;
    rst_n = 1'b0;
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    link_ready = 1'b0;
    dac_ddata = '0;
    dac_dunf = 1'b0;
    errors = 0;
    beats_checked = 0;
    check_dma = 1'b0;
    prev_accept = 1'b1;
    prev_data = '0;
    lcg_state = 32'h137b6db5;
    repeat (16) tick();
    rst_n = 1'b1;

    // reset state
    n = 0;
    while (!link_valid && n < 20) begin
      tick();
      n++;
    end
    assert (link_valid) else begin
      $display("link_valid never rose after reset");
      errors++;
    end
    assert (link_data == '0) else begin
      $display("error link_data expected %h actual %h", 64'h0, link_data);
      errors++;
    end
    assert (dac_valid == '0) else begin
      $display("error dac_valid expected %h actual %h", 2'h0, dac_valid);
      errors++;
    end
    assert (enable == '0) else begin
      $display("error enable expected %h actual %h", 2'h0, enable);
      errors++;
    end
    check_reg(reg_addr_id, 32'h6a54_0d01);
    check_reg(reg_addr_link, {8'd0, 8'd16, 8'd2, 8'd2});

    // dma with steady and random ready
    run_dma(40, 1'b0);
    run_dma(80, 1'b1);

    // pattern on channel 0, zero on channel 1
    reg_write(reg_addr_pattern, 32'habcd_1234);
    reg_write(reg_addr_chan_ctrl, 32'h11);
    reg_write(reg_addr_chan_ctrl + 8'd1, 32'h13);
    check_static(expected_beat({16'h0, 16'h0, 16'habcd, 16'h1234}), 8);
    reg_write(reg_addr_chan_ctrl, 32'h01);
    check_static('0, 4);
    assert (enable == 2'b10) else begin
      $display("error enable expected %h actual %h", 2'b10, enable);
      errors++;
    end

    // ramp on channel 1, compared beat to beat
    reg_write(reg_addr_chan_ctrl + 8'd1, 32'h12);
    link_ready = 1'b1;
    repeat (4) tick();
    prev_s0 = lane_sample(link_data, 1, 0);
    last = link_data;
    beats = 0;
    n = 0;
    while (beats < 40 && n < 400) begin
      lcg_state = lcg_next(lcg_state);
      link_ready = lcg_state[15:8] < 8'd170;
      tick();
      n++;
      if (link_ready) begin
        assert (lane_sample(link_data, 1, 0) == prev_s0 + 16'd2 &&
                lane_sample(link_data, 1, 1) == prev_s0 + 16'd3 &&
                link_data[31:0] == 32'h0) else begin
          $display("error link_data expected ramp from %h actual %h", prev_s0 + 16'd2,
                   link_data);
          errors++;
        end
        prev_s0 = lane_sample(link_data, 1, 0);
        beats++;
      end else begin
        assert (link_data == last) else begin
          $display("error link_data expected %h actual %h", last, link_data);
          errors++;
        end
      end
      last = link_data;
    end
    assert (beats >= 40) else begin
      $display("timed out waiting for ramp beats");
      errors++;
    end
    link_ready = 1'b1;

    // sticky underflow, write one to clear
    check_reg(reg_addr_status, 32'h0);
    dac_dunf = 1'b1;
    tick();
    dac_dunf = 1'b0;
    tick();
    check_reg(reg_addr_status, 32'h1);
    check_reg(reg_addr_status, 32'h1);
    reg_write(reg_addr_status, 32'h1);
    check_reg(reg_addr_status, 32'h0);

    $display("errors %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- flist.f
dac_tpl_pkg.sv
dac_tpl_regmap.sv
dac_tpl_source.sv
dac_tpl_framer.sv
dac_tpl_top.sv
dac_tpl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module dac_tpl_tb \
  -Mdir obj_dir \
  -o dac_tpl_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/dac_tpl_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* PASS \*\*' "$log"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
